//--- Makefile
TOP = tb_cluster

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o sim_cluster

run: compile
	./obj_dir/sim_cluster > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Test failures found" sim.log; then \
	  echo "Simulation FAILED"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- rtl/cluster_addr_demux.sv
////////////////////
// Address demux: routes each request to TCDM,
// peripherals or the outbound port, muxes the response
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "cluster_macros.svh"

module cluster_addr_demux
  import cluster_bus_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  bus_req_t in_req,
  output bus_rsp_t in_rsp,
  output bus_req_t tcdm_req,
  output bus_req_t periph_req,
  output bus_req_t out_req,
  input  bus_rsp_t tcdm_rsp,
  input  bus_rsp_t periph_rsp,
  input  bus_rsp_t out_rsp
);

  localparam logic [`ADDR_WIDTH-1:0] tcdm_end = `CLUSTER_BASE + `TCDM_SIZE_BYTES;

  target_e tgt;
  target_e tgt_q;
  logic    pend_q;

  // Decode
  always_comb begin
    if (in_req.addr >= `CLUSTER_BASE && in_req.addr < tcdm_end) begin
      tgt = tgt_tcdm;
    end else if (in_req.addr >= `PERIPH_BASE && in_req.addr < `CLUSTER_END) begin
      tgt = tgt_periph;
    end else if (in_req.addr >= `CLUSTER_BASE && in_req.addr < `CLUSTER_END) begin
      // Hole inside the cluster range
      tgt = tgt_none;
    end else begin
      tgt = tgt_out;
    end
  end

  // Fan out with valid gated per target
  always_comb begin
    tcdm_req         = in_req;
    periph_req       = in_req;
    out_req          = in_req;
    tcdm_req.valid   = in_req.valid && (tgt == tgt_tcdm);
    periph_req.valid = in_req.valid && (tgt == tgt_periph);
    out_req.valid    = in_req.valid && (tgt == tgt_out);
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      pend_q <= 1'b0;
      tgt_q  <= tgt_none;
    end else begin
      pend_q <= in_req.valid;
      tgt_q  <= tgt;
    end
  end

  ////////////////////
  // Response select
  ////////////////////
  always_comb begin
    in_rsp = '0;
    if (pend_q) begin
      case (tgt_q)
        tgt_tcdm:   in_rsp = tcdm_rsp;
        tgt_periph: in_rsp = periph_rsp;
        tgt_out:    in_rsp = out_rsp;
        default: begin
          in_rsp.valid = 1'b1;
          in_rsp.err   = 1'b1;
        end
      endcase
    end
  end

  // The addressed target, and only that one, answers in the next cycle
  a_one_rsp: assert property (@(posedge clk) disable iff (rst_n)
    (pend_q && tgt_q != tgt_none) |->
      $onehot({tcdm_rsp.valid, periph_rsp.valid, out_rsp.valid}));

endmodule

`default_nettype wire

//--- rtl/cluster_bus_pkg.sv
////////////////////
// Narrow bus types: single-beat request and
// response structs plus the route selector
////////////////////
`default_nettype none

`include "cluster_macros.svh"

package cluster_bus_pkg;

  // One request beat, valid for a single cycle
  typedef struct packed {
    logic                      valid;
    logic                      write;
    logic [`ADDR_WIDTH-1:0]    addr;
    logic [`DATA_WIDTH-1:0]    wdata;
    logic [`DATA_WIDTH/8-1:0]  strb;
  } bus_req_t;

  // Response, always one cycle after its request
  typedef struct packed {
    logic                      valid;
    logic                      err;
    logic [`DATA_WIDTH-1:0]    rdata;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    tgt_tcdm,
    tgt_periph,
    tgt_out,
    tgt_none
  } target_e;

endpackage

`default_nettype wire

//--- rtl/cluster_macros.svh
////////////////////
// Cluster constants: core count, bus widths,
// scratchpad depth and the cluster address map
////////////////////
`ifndef CLUSTER_MACROS_SVH
`define CLUSTER_MACROS_SVH

`define NR_CORES        4
`define ADDR_WIDTH      32
`define DATA_WIDTH      32
`define TCDM_WORDS      256

// Address map
`define CLUSTER_BASE    32'h1000_0000
`define TCDM_SIZE_BYTES 32'h0000_0400
`define PERIPH_BASE     (`CLUSTER_BASE + 32'h0001_0000)
`define CLUSTER_END     (`PERIPH_BASE + 32'h0000_1000)

`endif

//--- rtl/cluster_periph_pkg.sv
////////////////////
// Peripheral block types: register offsets
// and the per-core interrupt mask
////////////////////
`default_nettype none

`include "cluster_macros.svh"

package cluster_periph_pkg;

  // Byte offsets inside the 4 KiB peripheral region
  typedef enum logic [11:0] {
    scratch_0      = 12'h000,
    scratch_1      = 12'h008,
    cl_clint_set   = 12'h030,
    cl_clint_clear = 12'h038
  } periph_reg_e;

  // One bit per core
  typedef logic [`NR_CORES-1:0] core_mask_t;

endpackage

`default_nettype wire

//--- rtl/cluster_periph_regs.sv
////////////////////
// Cluster peripherals: scratch registers, cluster
// interrupt set/clear and the per-core interrupt OR
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "cluster_macros.svh"

module cluster_periph_regs
  import cluster_bus_pkg::*;
  import cluster_periph_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  bus_req_t   req,
  output bus_rsp_t   rsp,
  input  core_mask_t msip,
  output core_mask_t core_irq
);

  periph_reg_e            reg_off;
  logic [`DATA_WIDTH-1:0] scratch_0_q;
  logic [`DATA_WIDTH-1:0] scratch_1_q;
  core_mask_t             mask_q;
  core_mask_t             mask_d;
  logic                   known;
  logic [`DATA_WIDTH-1:0] rd_val;

  assign reg_off = periph_reg_e'(req.addr[11:0]);

  ////////////////////
  // Decode
  ////////////////////
  always_comb begin
    known  = 1'b1;
    rd_val = '0;
    mask_d = mask_q;
    case (reg_off)
      scratch_0: rd_val = scratch_0_q;
      scratch_1: rd_val = scratch_1_q;
      cl_clint_set: begin
        rd_val = `DATA_WIDTH'(mask_q);
        if (req.valid && req.write) mask_d = mask_q | req.wdata[`NR_CORES-1:0];
      end
      cl_clint_clear: begin
        rd_val = `DATA_WIDTH'(mask_q);
        if (req.valid && req.write) mask_d = mask_q & ~req.wdata[`NR_CORES-1:0];
      end
      default: known = 1'b0;
    endcase
  end

  // Registers take the whole word, strobes are not used here
  always_ff @(posedge clk) begin
    if (rst_n) begin
      scratch_0_q <= '0;
      scratch_1_q <= '0;
      mask_q      <= '0;
      core_irq    <= '0;
      rsp         <= '0;
    end else begin
      mask_q <= mask_d;
      if (req.valid && req.write && reg_off == scratch_0) scratch_0_q <= req.wdata;
      if (req.valid && req.write && reg_off == scratch_1) scratch_1_q <= req.wdata;
      // Next mask so a clint write shows up with its response
      core_irq  <= msip | mask_d;
      rsp.valid <= req.valid;
      rsp.err   <= req.valid && !known;
      rsp.rdata <= (req.valid && !req.write && known) ? rd_val : '0;
    end
  end

  a_irq_reset: assert property (@(posedge clk) rst_n |=> core_irq == '0);

endmodule

`default_nettype wire

//--- rtl/cluster_tcdm.sv
////////////////////
// TCDM scratchpad, word array with byte strobes
// and a one-cycle read, cleared by a reset sweep
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "cluster_macros.svh"

module cluster_tcdm
  import cluster_bus_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  bus_req_t req,
  output bus_rsp_t rsp
);

  localparam int idx_w = $clog2(`TCDM_WORDS);

  logic [`DATA_WIDTH-1:0] mem [`TCDM_WORDS];
  logic [idx_w-1:0]       idx;
  logic [idx_w-1:0]       sweep_idx;
  logic                   sweep_busy;

  // Word index sits above the byte offset
  assign idx = req.addr[idx_w+1:2];

  // Sweep runs on after reset until every word is zero
  always_ff @(posedge clk) begin
    if (rst_n) begin
      sweep_idx  <= '0;
      sweep_busy <= 1'b1;
      rsp        <= '0;
    end else begin
      if (sweep_busy) begin
        sweep_idx  <= sweep_idx + 1'b1;
        sweep_busy <= (sweep_idx != idx_w'(`TCDM_WORDS - 1));
      end
      rsp.valid <= req.valid;
      rsp.err   <= 1'b0;
      rsp.rdata <= (req.valid && !req.write) ? mem[idx] : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (sweep_busy) begin
      mem[sweep_idx] <= '0;
    end else if (req.valid && req.write) begin
      for (int b = 0; b < `DATA_WIDTH/8; b++) begin
        if (req.strb[b]) mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
      end
    end
  end

  a_in_range: assert property (@(posedge clk) disable iff (rst_n)
    req.valid |-> (req.addr >= `CLUSTER_BASE &&
                   req.addr < `CLUSTER_BASE + `TCDM_SIZE_BYTES));

endmodule

`default_nettype wire

//--- rtl/cluster_top.sv
////////////////////
// Cluster shell top: narrow port demux into
// TCDM, peripherals and the outbound port
////////////////////
`timescale 1ns/1ps
`default_nettype none

module cluster_top
  import cluster_bus_pkg::*;
  import cluster_periph_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  bus_req_t   narrow_in_req,
  output bus_rsp_t   narrow_in_rsp,
  output bus_req_t   narrow_out_req,
  input  bus_rsp_t   narrow_out_rsp,
  input  core_mask_t msip,
  output core_mask_t core_irq
);

  bus_req_t tcdm_req;
  bus_rsp_t tcdm_rsp;
  bus_req_t periph_req;
  bus_rsp_t periph_rsp;

  cluster_addr_demux i_demux (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_req     (narrow_in_req),
    .in_rsp     (narrow_in_rsp),
    .tcdm_req   (tcdm_req),
    .periph_req (periph_req),
    .out_req    (narrow_out_req),
    .tcdm_rsp   (tcdm_rsp),
    .periph_rsp (periph_rsp),
    .out_rsp    (narrow_out_rsp)
  );

  cluster_tcdm i_tcdm (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (tcdm_req),
    .rsp   (tcdm_rsp)
  );

  // Interrupt lines pass through the peripheral block
  cluster_periph_regs i_periph (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (periph_req),
    .rsp      (periph_rsp),
    .msip     (msip),
    .core_irq (core_irq)
  );

endmodule

`default_nettype wire

//--- tb/cluster_vip.sv
////////////////////
// Cluster VIP: clock, reset, msip, narrow bus
// tasks and the outbound memory model
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "cluster_macros.svh"

module cluster_vip
  import cluster_bus_pkg::*;
  import cluster_periph_pkg::*;
(
  output logic       clk,
  output logic       rst_n,
  output bus_req_t   narrow_in_req,
  input  bus_rsp_t   narrow_in_rsp,
  input  bus_req_t   narrow_out_req,
  output bus_rsp_t   narrow_out_rsp,
  output core_mask_t msip
);

  // Outbound memory, word aligned keys
  logic [`DATA_WIDTH-1:0] ext_mem [logic [`ADDR_WIDTH-1:0]];

  always begin
    clk = 1'b0;
    #5;
    clk = 1'b1;
    #5;
  end

  initial begin
    rst_n          = 1'b1;
    narrow_in_req  = '0;
    narrow_out_rsp = '0;
    msip           = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b0;
  end

  ////////////////////
  // Bus tasks
  ////////////////////
  task automatic strobe_req(input logic write, input logic [`ADDR_WIDTH-1:0] addr,
                            input logic [`DATA_WIDTH-1:0] wdata,
                            input logic [`DATA_WIDTH/8-1:0] strb);
    bus_req_t req;
    req.valid = 1'b1;
    req.write = write;
    req.addr  = addr;
    req.wdata = wdata;
    req.strb  = strb;
    @(posedge clk);
    narrow_in_req <= req;
  endtask

  task automatic release_req();
    @(posedge clk);
    narrow_in_req <= '0;
  endtask

  task automatic narrow_write(input logic [`ADDR_WIDTH-1:0] addr,
                              input logic [`DATA_WIDTH-1:0] wdata,
                              input logic [`DATA_WIDTH/8-1:0] strb, output bus_rsp_t rsp);
    strobe_req(1'b1, addr, wdata, strb);
    release_req();
    @(negedge clk);
    rsp = narrow_in_rsp;
  endtask

  task automatic narrow_read(input logic [`ADDR_WIDTH-1:0] addr, output bus_rsp_t rsp);
    strobe_req(1'b0, addr, '0, '0);
    release_req();
    @(negedge clk);
    rsp = narrow_in_rsp;
  endtask

  task automatic set_msip(input core_mask_t mask);
    @(posedge clk);
    msip <= mask;
  endtask

  // Reset release plus the TCDM clear sweep
  task automatic wait_reset_done();
    @(posedge clk);
    while (rst_n) @(posedge clk);
    repeat (`TCDM_WORDS + 2) @(posedge clk);
  endtask

  ////////////////////
  // Outbound responder
  ////////////////////
  always @(posedge clk) begin : serve_outbound
    bus_rsp_t               rsp;
    logic [`ADDR_WIDTH-1:0] a;
    logic [`DATA_WIDTH-1:0] word;
    rsp = '0;
    if (!rst_n && narrow_out_req.valid) begin
      a    = narrow_out_req.addr & ~32'h3;
      word = ext_mem.exists(a) ? ext_mem[a] : a ^ 32'hA5A5_A5A5;
      rsp.valid = 1'b1;
      if (narrow_out_req.write) begin
        for (int b = 0; b < `DATA_WIDTH/8; b++) begin
          if (narrow_out_req.strb[b]) word[8*b +: 8] = narrow_out_req.wdata[8*b +: 8];
        end
        ext_mem[a] = word;
      end else begin
        rsp.rdata = word;
      end
    end
    narrow_out_rsp <= rsp;
  end

endmodule

`default_nettype wire

//--- tb/tb_cluster.sv
////////////////////
// Cluster testbench: reference model, response
// checker, watchdog and the test sequence
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "cluster_macros.svh"

module tb_cluster
  import cluster_bus_pkg::*;
  import cluster_periph_pkg::*;
();

  localparam logic [31:0] entry_point = 32'h1c00_8080;
  localparam logic [31:0] out_base    = 32'h8000_0000;
  localparam logic [31:0] all_cores   = (32'd1 << `NR_CORES) - 32'd1;
  localparam int          tcdm_aw     = $clog2(`TCDM_WORDS);
  localparam int          num_wr      = 24;
  // Strobe cycle plus response cycle per transaction
  localparam int          txn_cycles  = 2 * 110;
  localparam int          limit_ns    = (txn_cycles + `TCDM_WORDS + 100) * 10;

  logic       clk;
  logic       rst_n;
  bus_req_t   narrow_in_req;
  bus_rsp_t   narrow_in_rsp;
  bus_req_t   narrow_out_req;
  bus_rsp_t   narrow_out_rsp;
  core_mask_t msip;
  core_mask_t core_irq;

  // Reference model state
  logic [31:0] tcdm_model [`TCDM_WORDS];
  logic [31:0] scratch_model [2];
  core_mask_t  mask_model;
  logic [31:0] ext_model [logic [31:0]];
  logic [31:0] rng_state = 32'h4f0e;
  int          checks = 0;
  int          errors = 0;

  cluster_top i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .narrow_in_req  (narrow_in_req),
    .narrow_in_rsp  (narrow_in_rsp),
    .narrow_out_req (narrow_out_req),
    .narrow_out_rsp (narrow_out_rsp),
    .msip           (msip),
    .core_irq       (core_irq)
  );

  cluster_vip i_vip (
    .clk            (clk),
    .rst_n          (rst_n),
    .narrow_in_req  (narrow_in_req),
    .narrow_in_rsp  (narrow_in_rsp),
    .narrow_out_req (narrow_out_req),
    .narrow_out_rsp (narrow_out_rsp),
    .msip           (msip)
  );

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic void check_value(input string name, input logic [31:0] got,
                                      input logic [31:0] want);
    checks++;
    assert (got === want) else begin
      $display("CHECK FAILED: %s exp %h got %h", name, want, got);
      errors++;
    end
  endfunction

  ////////////////////
  // Reference model
  ////////////////////
  function automatic target_e route_of(input logic [31:0] addr);
    if (addr >= `CLUSTER_BASE && addr < `CLUSTER_BASE + `TCDM_SIZE_BYTES) return tgt_tcdm;
    if (addr >= `PERIPH_BASE && addr < `CLUSTER_END) return tgt_periph;
    if (addr >= `CLUSTER_BASE && addr < `CLUSTER_END) return tgt_none;
    return tgt_out;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                              input logic [31:0] wdata, input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = wdata[8*b +: 8];
    end
    return res;
  endfunction

  // Unwritten outbound words hold a pattern of their address
  function automatic logic [31:0] ext_read(input logic [31:0] addr);
    logic [31:0] a;
    a = addr & ~32'h3;
    if (ext_model.exists(a)) return ext_model[a];
    return a ^ 32'hA5A5_A5A5;
  endfunction

  function automatic bus_rsp_t ref_rsp(input bus_req_t req);
    bus_rsp_t want;
    want       = '0;
    want.valid = 1'b1;
    case (route_of(req.addr))
      tgt_tcdm: if (!req.write) want.rdata = tcdm_model[req.addr[tcdm_aw+1:2]];
      tgt_periph: begin
        case (req.addr[11:0])
          12'h000: if (!req.write) want.rdata = scratch_model[0];
          12'h008: if (!req.write) want.rdata = scratch_model[1];
          12'h030, 12'h038: if (!req.write) want.rdata = 32'(mask_model);
          default: want.err = 1'b1;
        endcase
      end
      tgt_out: if (!req.write) want.rdata = ext_read(req.addr);
      default: want.err = 1'b1;
    endcase
    return want;
  endfunction

  function automatic void apply_write(input bus_req_t req);
    logic [tcdm_aw-1:0] idx;
    idx = req.addr[tcdm_aw+1:2];
    case (route_of(req.addr))
      tgt_tcdm: tcdm_model[idx] = merge_bytes(tcdm_model[idx], req.wdata, req.strb);
      tgt_periph: begin
        case (req.addr[11:0])
          12'h000: scratch_model[0] = req.wdata;
          12'h008: scratch_model[1] = req.wdata;
          12'h030: mask_model = mask_model | req.wdata[`NR_CORES-1:0];
          12'h038: mask_model = mask_model & ~req.wdata[`NR_CORES-1:0];
          default: ;
        endcase
      end
      tgt_out: ext_model[req.addr & ~32'h3] = merge_bytes(ext_read(req.addr), req.wdata, req.strb);
      default: ;
    endcase
  endfunction

  // Every strobe is answered at the following negedge
  initial begin : compare_responses
    bus_rsp_t   want;
    bus_rsp_t   got;
    logic       rsp_due;
    logic       irq_due;
    logic       out_want;
    core_mask_t irq_want;
    rsp_due  = 1'b0;
    irq_due  = 1'b0;
    want     = '0;
    irq_want = '0;
    forever begin
      @(negedge clk);
      if (rst_n !== 1'b0) begin
        rsp_due = 1'b0;
        irq_due = 1'b0;
      end else begin
        got = narrow_in_rsp;
        check_value("narrow_in_rsp.valid", 32'(got.valid), 32'(rsp_due));
        if (rsp_due) begin
          check_value("narrow_in_rsp.err", 32'(got.err), 32'(want.err));
          check_value("narrow_in_rsp.rdata", got.rdata, want.rdata);
        end
        if (irq_due) check_value("core_irq", 32'(core_irq), 32'(irq_want));
        out_want = narrow_in_req.valid && route_of(narrow_in_req.addr) == tgt_out;
        check_value("narrow_out_req.valid", 32'(narrow_out_req.valid), 32'(out_want));
        // Outbound beat carries the incoming request unchanged
        if (out_want) begin
          check_value("narrow_out_req.write", 32'(narrow_out_req.write),
                      32'(narrow_in_req.write));
          check_value("narrow_out_req.addr", narrow_out_req.addr, narrow_in_req.addr);
          check_value("narrow_out_req.wdata", narrow_out_req.wdata, narrow_in_req.wdata);
          check_value("narrow_out_req.strb", 32'(narrow_out_req.strb),
                      32'(narrow_in_req.strb));
        end
        rsp_due = narrow_in_req.valid;
        if (narrow_in_req.valid) begin
          want = ref_rsp(narrow_in_req);
          if (narrow_in_req.write) apply_write(narrow_in_req);
        end
        irq_want = msip | mask_model;
        irq_due  = 1'b1;
      end
    end
  end

  initial begin : watchdog
    #(limit_ns);
    $display("Timeout: test sequence still running after %0d ns", limit_ns);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("Test failures found");
    $finish;
  end

  ////////////////////
  // Test sequence
  ////////////////////
  initial begin : test_sequence
    bus_rsp_t    rsp;
    logic [31:0] r;
    logic [31:0] data;
    logic [31:0] addr;
    logic [31:0] wr_addr [num_wr];
    logic [31:0] bad_addr [4];
    mask_model       = '0;
    scratch_model[0] = '0;
    scratch_model[1] = '0;
    for (int i = 0; i < `TCDM_WORDS; i++) tcdm_model[i] = '0;
    i_vip.wait_reset_done();

    // TCDM cleared, then byte-strobed writes on a few words
    for (int i = 0; i < 8; i++) begin
      r = next_rand();
      i_vip.narrow_read(`CLUSTER_BASE + (r & 32'h0000_03fc), rsp);
      check_value("tcdm rdata after sweep", rsp.rdata, 32'h0);
    end
    for (int i = 0; i < num_wr; i++) begin
      r          = next_rand();
      wr_addr[i] = `CLUSTER_BASE + (r & 32'h0000_003c);
      data       = next_rand();
      i_vip.narrow_write(wr_addr[i], data, r[11:8], rsp);
    end
    for (int i = 0; i < num_wr; i++) i_vip.narrow_read(wr_addr[i], rsp);

    // Scratch registers
    data = next_rand();
    i_vip.narrow_write(`PERIPH_BASE + 32'h00, data, 4'hf, rsp);
    i_vip.narrow_write(`PERIPH_BASE + 32'h08, entry_point, 4'hf, rsp);
    i_vip.narrow_read(`PERIPH_BASE + 32'h08, rsp);
    check_value("scratch_1 rdata", rsp.rdata, entry_point);
    i_vip.narrow_read(`PERIPH_BASE + 32'h00, rsp);
    check_value("scratch_0 rdata", rsp.rdata, data);

    // Cluster interrupt set and clear, then msip alone
    i_vip.narrow_write(`PERIPH_BASE + 32'h30, 32'hffff_ffff, 4'hf, rsp);
    check_value("core_irq", 32'(core_irq), all_cores);
    i_vip.narrow_write(`PERIPH_BASE + 32'h38, 32'h0000_0005, 4'hf, rsp);
    check_value("core_irq", 32'(core_irq), all_cores & ~32'h5);
    i_vip.narrow_read(`PERIPH_BASE + 32'h30, rsp);
    check_value("cl_clint_set rdata", rsp.rdata, all_cores & ~32'h5);
    i_vip.narrow_write(`PERIPH_BASE + 32'h38, all_cores, 4'hf, rsp);
    for (int i = 0; i < 8; i++) begin
      r = next_rand();
      i_vip.set_msip(r[`NR_CORES-1:0]);
      @(posedge clk);
      @(negedge clk);
      check_value("core_irq from msip", 32'(core_irq), 32'(r[`NR_CORES-1:0]));
    end
    i_vip.set_msip('0);

    // Outbound port
    for (int i = 0; i < 4; i++) begin
      r          = next_rand();
      wr_addr[i] = out_base + (r & 32'h0000_fffc);
      i_vip.narrow_read(wr_addr[i], rsp);
      check_value("outbound rdata", rsp.rdata, wr_addr[i] ^ 32'hA5A5_A5A5);
    end
    for (int i = 0; i < 4; i++) i_vip.narrow_write(wr_addr[i], next_rand(), 4'hf, rsp);
    for (int i = 0; i < 4; i++) i_vip.narrow_read(wr_addr[i], rsp);
    i_vip.narrow_read(32'h0000_1000, rsp);

    // Holes and unknown peripheral offsets
    bad_addr[0] = `CLUSTER_BASE + `TCDM_SIZE_BYTES;
    bad_addr[1] = `PERIPH_BASE - 32'h4;
    bad_addr[2] = `PERIPH_BASE + 32'h004;
    bad_addr[3] = `PERIPH_BASE + 32'h100;
    for (int i = 0; i < 4; i++) begin
      i_vip.narrow_read(bad_addr[i], rsp);
      check_value("err on unmapped read", 32'(rsp.err), 32'h1);
      check_value("rdata on unmapped read", rsp.rdata, 32'h0);
    end
    i_vip.narrow_write(`CLUSTER_BASE + 32'h0000_8000, next_rand(), 4'hf, rsp);

    // Back-to-back strobes rotating over the three targets
    for (int i = 0; i < 12; i++) begin
      r = next_rand();
      case (i % 3)
        0:       addr = `CLUSTER_BASE + (r & 32'h0000_003c);
        1:       addr = `PERIPH_BASE + ((i % 2 == 1) ? 32'h0 : 32'h8);
        default: addr = wr_addr[i % 4];
      endcase
      i_vip.strobe_req((i % 2) == 0, addr, next_rand(), r[3:0]);
    end
    i_vip.release_req();
    repeat (3) @(negedge clk);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+rtl
rtl/cluster_bus_pkg.sv
rtl/cluster_periph_pkg.sv
rtl/cluster_addr_demux.sv
rtl/cluster_tcdm.sv
rtl/cluster_periph_regs.sv
rtl/cluster_top.sv
tb/cluster_vip.sv
tb/tb_cluster.sv
